// File: rtl/mq_pkg.sv
package mq_pkg;

  // Data word
  localparam int DATA_W = 32;
  typedef logic [DATA_W-1:0] data_t;

  // Queue numbering, sized for the largest supported configuration
  localparam int MAX_QUEUES = 4;
  localparam int QID_W      = $clog2(MAX_QUEUES);
  typedef logic [QID_W-1:0] qid_t;

  // Slot index inside one queue region
  localparam int MAX_DEPTH = 16;
  localparam int PTR_W     = $clog2(MAX_DEPTH);
  typedef logic [PTR_W-1:0] ptr_t;

  // One extra bit so a completely full queue can be counted
  typedef logic [PTR_W:0] occ_t;

  // Shared downstream credit pool
  localparam int CREDIT_W = 5;
  typedef logic [CREDIT_W-1:0] credit_t;

  // Egress sequencing
  // EGR_IDLE  waiting for a non-empty queue and a credit
  // EGR_READ  memory read in progress
  // EGR_HOLD  read data captured into the output register
  typedef enum logic [1:0] {
    EGR_IDLE,
    EGR_READ,
    EGR_HOLD
  } egr_state_t;

endpackage

// File: rtl/mq_if.sv
`timescale 1ns/1ps

// Push path from ingress into pointers and memory
interface mq_wr_if
  import mq_pkg::*;
();
  logic  wr_en;    // One word per cycle
  qid_t  wr_queue; // Target queue
  ptr_t  wr_ptr;   // Slot from the pointer manager
  data_t wr_data;

  modport ingress (output wr_en, output wr_queue, output wr_data);
  modport ptr     (input wr_en, input wr_queue, output wr_ptr);
  modport mem     (input wr_en, input wr_queue, input wr_ptr, input wr_data);
endinterface

// Pop path from egress through pointers and memory
interface mq_rd_if
  import mq_pkg::*;
#(
  parameter int NUM_QUEUES = MAX_QUEUES
) ();
  logic                  rd_en;
  qid_t                  rd_queue;
  ptr_t                  rd_ptr;    // Head slot of rd_queue
  data_t                 rd_data;   // Registered read word
  logic [NUM_QUEUES-1:0] empty_vec; // One flag per queue
  logic                  rd_valid;  // rd_data valid, one cycle after rd_en

  modport egress (output rd_en, output rd_queue, input rd_data, input rd_valid, input empty_vec);
  modport ptr    (input rd_en, input rd_queue, output rd_ptr, output empty_vec);
  modport mem    (input rd_en, input rd_queue, input rd_ptr, output rd_data, output rd_valid);
endinterface

// File: rtl/ptr_mngr.sv
`timescale 1ns/1ps

module ptr_mngr
  import mq_pkg::*;
#(
  parameter int NUM_QUEUES  = 4,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  mq_wr_if.ptr                  wr,
  mq_rd_if.ptr                  rd,
  output logic [NUM_QUEUES-1:0] full_vec
);

  localparam ptr_t LAST_SLOT = ptr_t'(QUEUE_DEPTH - 1);
  localparam occ_t DEPTH_OCC = occ_t'(QUEUE_DEPTH);

  ptr_t wr_ptr_q [NUM_QUEUES]; // Next slot to write
  ptr_t rd_ptr_q [NUM_QUEUES]; // Head slot
  occ_t occ_q    [NUM_QUEUES]; // Words stored per queue

  logic [NUM_QUEUES-1:0] push;
  logic [NUM_QUEUES-1:0] pop;

  // Wrap inside the queue region
  function automatic ptr_t next_ptr(input ptr_t p);
    return (p == LAST_SLOT) ? '0 : p + 1'b1;
  endfunction

  // Flags straight from occupancy, so empty drops on a write and rises on the last read
  always_comb
  begin
    for (int q = 0; q < NUM_QUEUES; q++)
    begin
      rd.empty_vec[q] = (occ_q[q] == '0);
      full_vec[q]     = (occ_q[q] == DEPTH_OCC);
    end
  end

  // Decode per queue, overflow and underflow requests dropped here
  always_comb
  begin
    for (int q = 0; q < NUM_QUEUES; q++)
    begin
      push[q] = wr.wr_en && (wr.wr_queue == qid_t'(q)) && !full_vec[q];
      pop[q]  = rd.rd_en && (rd.rd_queue == qid_t'(q)) && !rd.empty_vec[q];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int q = 0; q < NUM_QUEUES; q++)
      begin
        wr_ptr_q[q] <= '0;
        rd_ptr_q[q] <= '0;
        occ_q[q]    <= '0;
      end
    end
    else
    begin
      for (int q = 0; q < NUM_QUEUES; q++)
      begin
        case ({push[q], pop[q]})
          2'b10:   // Write only
          begin
            wr_ptr_q[q] <= next_ptr(wr_ptr_q[q]);
            occ_q[q]    <= occ_q[q] + 1'b1;
          end
          2'b01:   // Read only
          begin
            rd_ptr_q[q] <= next_ptr(rd_ptr_q[q]);
            occ_q[q]    <= occ_q[q] - 1'b1;
          end
          2'b11:   // Both pointers move, occupancy unchanged
          begin
            wr_ptr_q[q] <= next_ptr(wr_ptr_q[q]);
            rd_ptr_q[q] <= next_ptr(rd_ptr_q[q]);
          end
          default: ; // Idle
        endcase
      end
    end
  end

  // Pointers for the queues being addressed this cycle
  assign wr.wr_ptr = wr_ptr_q[wr.wr_queue];
  assign rd.rd_ptr = rd_ptr_q[rd.rd_queue];

endmodule

// File: rtl/ingress_stage.sv
`timescale 1ns/1ps

module ingress_stage
  import mq_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  qid_t     in_queue,
  input  data_t    in_data,
  mq_wr_if.ingress wr
);

  // Input register stage
  logic  valid_q;
  qid_t  queue_q;
  data_t data_q;

  // Valid is the only control bit here
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= in_valid;
    end
  end

  // Capture word and tag only on a real transfer
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      queue_q <= in_queue;
      data_q  <= in_data;
    end
  end

  // Push presented one cycle after sampling
  // Space is guaranteed by upstream credits
  assign wr.wr_en    = valid_q;
  assign wr.wr_queue = queue_q;
  assign wr.wr_data  = data_q; // Written at wr_ptr on the next edge

endmodule

// File: rtl/queue_mem.sv
`timescale 1ns/1ps

module queue_mem
  import mq_pkg::*;
#(
  parameter int NUM_QUEUES  = 4,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic clk,
  input  logic rst_n,
  mq_wr_if.mem wr,
  mq_rd_if.mem rd
);

  localparam int SLOT_W    = $clog2(QUEUE_DEPTH);
  localparam int ADDR_W    = QID_W + SLOT_W;
  localparam int MEM_WORDS = NUM_QUEUES * QUEUE_DEPTH;

  data_t             mem [MEM_WORDS]; // One region of QUEUE_DEPTH words per queue
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;

  // Queue number on top, slot index below
  assign wr_addr = {wr.wr_queue, wr.wr_ptr[SLOT_W-1:0]};
  assign rd_addr = {rd.rd_queue, rd.rd_ptr[SLOT_W-1:0]};

  always_ff @(posedge clk)
  begin
    if (wr.wr_en)
      mem[wr_addr] <= wr.wr_data;
    if (rd.rd_en)
      rd.rd_data <= mem[rd_addr]; // Registered read port
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rd.rd_valid <= 1'b0;
    else
      rd.rd_valid <= rd.rd_en; // Tracks rd_data by one cycle
  end

endmodule

// File: rtl/egress_stage.sv
`timescale 1ns/1ps

module egress_stage
  import mq_pkg::*;
#(
  parameter int NUM_QUEUES  = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic    clk,
  input  logic    rst_n,
  mq_rd_if.egress rd,
  input  logic    out_credit,
  output logic    out_valid,
  output qid_t    out_queue,
  output data_t   out_data,
  output logic    in_credit,
  output qid_t    in_credit_queue
);

  egr_state_t state;
  qid_t       serve_q;    // Queue in flight, also the round-robin base
  qid_t       pick_q;
  logic       pick_found;
  logic       issue;      // Start a pop this edge
  logic       spend;      // Word delivered this edge
  credit_t    credits;    // Shared downstream pool

  // Round-robin search, first non-empty queue after the last one served
  always_comb
  begin
    int idx;
    pick_found = 1'b0;
    pick_q     = serve_q;
    for (int off = 1; off <= NUM_QUEUES; off++)
    begin
      idx = (int'(serve_q) + off) % NUM_QUEUES;
      if (!pick_found && !rd.empty_vec[idx])
      begin
        pick_found = 1'b1;
        pick_q     = qid_t'(idx);
      end
    end
  end

  assign issue = (state == EGR_IDLE) && pick_found && (credits != '0);
  assign spend = (state == EGR_HOLD) && rd.rd_valid;

  assign rd.rd_en    = (state == EGR_READ); // Single-cycle pop request
  assign rd.rd_queue = serve_q;

  // One word in flight at a time
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= EGR_IDLE;
      serve_q <= qid_t'(NUM_QUEUES - 1); // Queue 0 gets the first turn
    end
    else
    begin
      case (state)
        EGR_IDLE:
        begin
          if (issue)
          begin
            state   <= EGR_READ;
            serve_q <= pick_q;
          end
        end
        EGR_READ: state <= EGR_HOLD; // Memory and pointers act on rd_en here
        EGR_HOLD:
        begin
          if (rd.rd_valid)
            state <= EGR_IDLE;
        end
        default:  state <= EGR_IDLE;
      endcase
    end
  end

  // Grant and spend may coincide
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      credits <= credit_t'(OUT_CREDITS);
    else if (out_credit && !spend)
      credits <= credits + 1'b1;
    else if (spend && !out_credit)
      credits <= credits - 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end
    else
    begin
      out_valid <= spend;
      in_credit <= spend; // Slot freed upstream with the delivered word
    end
  end

  always_ff @(posedge clk)
  begin
    if (spend)
    begin
      out_data        <= rd.rd_data;
      out_queue       <= serve_q;
      in_credit_queue <= serve_q;
    end
  end

endmodule

// File: rtl/mq_buffer_top.sv
`timescale 1ns/1ps

module mq_buffer_top
  import mq_pkg::*;
#(
  parameter int NUM_QUEUES  = 4,
  parameter int QUEUE_DEPTH = 8, // Power of two, at most MAX_DEPTH
  parameter int OUT_CREDITS = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  qid_t  in_queue,
  input  data_t in_data,
  input  logic  out_credit,
  output logic  in_credit,
  output qid_t  in_credit_queue,
  output logic  out_valid,
  output qid_t  out_queue,
  output data_t out_data
);

  mq_wr_if                            wr_if ();
  mq_rd_if #(.NUM_QUEUES(NUM_QUEUES)) rd_if ();

  ingress_stage u_ingress (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_queue (in_queue),
    .in_data  (in_data),
    .wr       (wr_if.ingress)
  );

  ptr_mngr #(
    .NUM_QUEUES  (NUM_QUEUES),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_ptr (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr_if.ptr),
    .rd       (rd_if.ptr),
    .full_vec ()
  );

  queue_mem #(
    .NUM_QUEUES  (NUM_QUEUES),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr_if.mem),
    .rd    (rd_if.mem)
  );

  egress_stage #(
    .NUM_QUEUES  (NUM_QUEUES),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_egress (
    .clk             (clk),
    .rst_n           (rst_n),
    .rd              (rd_if.egress),
    .out_credit      (out_credit),
    .out_valid       (out_valid),
    .out_queue       (out_queue),
    .out_data        (out_data),
    .in_credit       (in_credit),
    .in_credit_queue (in_credit_queue)
  );

endmodule

// File: bench/mq_buffer_tb.sv
`timescale 1ns/1ps

module mq_buffer_tb
  import mq_pkg::*;
();

  localparam int NUM_QUEUES  = 4;
  localparam int QUEUE_DEPTH = 8;
  localparam int OUT_CREDITS = 4;
  localparam int NUM_ROWS    = 5;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

  typedef enum int {CR_FREE, CR_WITHHELD, CR_TRICKLE} credit_mode_t;

  // Stimulus table: name, queue mask, word count, downstream credit mode
  string        row_name  [NUM_ROWS] = '{"single_q0", "interleave", "withheld",
                                          "full_drain", "mixed_trickle"};
  logic [3:0]   row_mask  [NUM_ROWS] = '{4'b0001, 4'b1111, 4'b0110, 4'b0100, 4'b1011};
  int           row_words [NUM_ROWS] = '{6, 24, 8, QUEUE_DEPTH, 12};
  credit_mode_t row_mode  [NUM_ROWS] = '{CR_FREE, CR_FREE, CR_WITHHELD, CR_TRICKLE, CR_TRICKLE};

  logic  clk;
  logic  rst_n;
  logic  in_valid;
  qid_t  in_queue;
  data_t in_data;
  logic  out_credit;
  logic  in_credit;
  qid_t  in_credit_queue;
  logic  out_valid;
  qid_t  out_queue;
  data_t out_data;

  data_t        model_q [NUM_QUEUES][$]; // Expected words per DUT queue
  int           up_cred [NUM_QUEUES];    // Upstream sender credits
  int           sent_row [NUM_QUEUES];
  int           ret_row [NUM_QUEUES];
  int           sent_total;
  int           rx_row;                  // Words received in current row
  int           owed;                    // Slots held by the DUT's credit pool
  logic         release_one;             // Single grant request, withheld mode
  credit_mode_t mode;
  string        cur_name;
  logic [31:0]  lfsr = 32'd13;

  mq_buffer_top #(
    .NUM_QUEUES  (NUM_QUEUES),
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .in_queue        (in_queue),
    .in_data         (in_data),
    .out_credit      (out_credit),
    .in_credit       (in_credit),
    .in_credit_queue (in_credit_queue),
    .out_valid       (out_valid),
    .out_queue       (out_queue),
    .out_data        (out_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
        lfsr = lfsr ^ LFSR_TAPS;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic bit models_empty();
    for (int q = 0; q < NUM_QUEUES; q++)
      if (model_q[q].size() != 0)
        return 1'b0;
    return 1'b1;
  endfunction

  task automatic report_error(input string what);
    $display("ERROR in %s: %s", cur_name, what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_queue(input string name, input qid_t exp, input qid_t act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected queue %0d, actual queue %0d", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "queue mismatch");
    end
  endtask

  task automatic check_count(input string name, input occ_t exp, input occ_t act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected count %0d, actual count %0d", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "count mismatch");
    end
  endtask

  // One word to a masked queue that still holds an upstream credit
  task automatic send_word(input logic [3:0] mask);
    bit   found;
    int   start;
    qid_t pick;
    found = 1'b0;
    pick  = '0;
    while (!found)
    begin
      @(posedge clk);
      #2;
      start = int'(rand_bits(2));
      for (int k = 0; k < NUM_QUEUES; k++)
      begin
        if (!found && mask[(start + k) % NUM_QUEUES] && up_cred[(start + k) % NUM_QUEUES] > 0)
        begin
          found = 1'b1;
          pick  = qid_t'((start + k) % NUM_QUEUES);
        end
      end
      in_valid = found; // Idle cycle while every masked queue is out of credit
    end
    in_queue = pick;
    in_data  = rand_bits(32);
    model_q[pick].push_back(in_data);
    up_cred[pick]--;  // Credit spent with the word
    sent_row[pick]++;
    sent_total++;
  endtask

  // Downstream receiver grants
  initial
  begin
    int tick;
    tick       = 0;
    out_credit = 1'b0;
    forever
    begin
      @(posedge clk);
      #2;
      tick++;
      out_credit = 1'b0;
      if (owed > 0 && (mode == CR_FREE || (mode == CR_TRICKLE && tick % 5 == 0) || release_one))
      begin
        out_credit  = 1'b1;
        owed--;
        release_one = 1'b0;
      end
    end
  end

  // Output monitor, sampled mid-cycle
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (sent_total == 0 && (out_valid === 1'b1 || in_credit === 1'b1))
        report_error("output activity before any word was sent");
      if (in_credit === 1'b1 && out_valid !== 1'b1)
        report_error("in_credit pulse without a delivered word");
      if (out_valid === 1'b1)
      begin
        if (in_credit !== 1'b1)
          report_error("delivered word came without an in_credit pulse");
        check_queue(cur_name, out_queue, in_credit_queue);
        if (model_q[out_queue].size() == 0)
          report_error("word delivered from a queue with nothing pending");
        check_data(cur_name, model_q[out_queue].pop_front(), out_data);
        rx_row++;
        owed++;                          // Receiver slot now occupied
        up_cred[in_credit_queue]++;
        ret_row[in_credit_queue]++;
        if (up_cred[in_credit_queue] > QUEUE_DEPTH)
          report_error("more upstream credits returned than words sent");
      end
    end
  end

  // Run limit from the table length
  initial
  begin
    int cycles;
    int limit;
    cycles = 0;
    limit  = 200;
    for (int i = 0; i < NUM_ROWS; i++)
      limit += row_words[i] * 8;
    while (cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

  initial
  begin
    int burst;
    int prev;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_queue    = '0;
    in_data     = '0;
    sent_total  = 0;
    rx_row      = 0;
    owed        = 0;
    release_one = 1'b0;
    mode        = CR_FREE;
    cur_name    = "reset";
    for (int q = 0; q < NUM_QUEUES; q++)
      up_cred[q] = QUEUE_DEPTH;
    repeat (16) @(posedge clk);
    #2 rst_n = 1'b1;
    repeat (5) @(negedge clk); // Outputs must stay quiet here

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      cur_name = row_name[r];
      mode     = row_mode[r];
      rx_row   = 0;
      for (int q = 0; q < NUM_QUEUES; q++)
      begin
        sent_row[q] = 0;
        ret_row[q]  = 0;
      end
      for (int w = 0; w < row_words[r]; w++)
        send_word(row_mask[r]);
      @(posedge clk);
      #2 in_valid = 1'b0;

      if (row_mode[r] == CR_WITHHELD)
      begin
        repeat (30) @(negedge clk);    // Pool should be spent by now
        burst = (row_words[r] < OUT_CREDITS) ? row_words[r] : OUT_CREDITS;
        check_count(cur_name, occ_t'(burst), occ_t'(rx_row));
        while (rx_row < row_words[r])
        begin
          prev        = rx_row;
          release_one = 1'b1;          // One grant, one word
          while (rx_row == prev)
            @(negedge clk);
          repeat (6) @(negedge clk);
          check_count(cur_name, occ_t'(prev + 1), occ_t'(rx_row));
        end
        mode = CR_FREE;                // Hand back the held slots
      end

      while (!models_empty() || owed != 0)
        @(negedge clk);
      repeat (3) @(negedge clk);
      check_count(cur_name, occ_t'(row_words[r]), occ_t'(rx_row));
      for (int q = 0; q < NUM_QUEUES; q++)
      begin
        check_count(cur_name, occ_t'(sent_row[q]), occ_t'(ret_row[q]));
        check_count(cur_name, occ_t'(QUEUE_DEPTH), occ_t'(up_cred[q])); // Full credit restored
      end
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: list.f
rtl/mq_pkg.sv
rtl/mq_if.sv
rtl/ptr_mngr.sv
rtl/ingress_stage.sv
rtl/queue_mem.sv
rtl/egress_stage.sv
rtl/mq_buffer_top.sv
bench/mq_buffer_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= mq_buffer_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
